// File: src/datapathPkg.sv
//////////////////////////////////////////////////
// Shared datapath types, ALU operations and the
// instruction register field layout
//////////////////////////////////////////////////
package datapathPkg;

   typedef logic [31:0] word_t;   // Bus and register word
   typedef logic [3:0]  regIdx_t; // Register number from an IR field
   typedef logic [18:0] const_t;  // Immediate field C

   typedef enum logic [3:0] {
      opAdd = 4'd0,
      opSub = 4'd1,
      opAnd = 4'd2,
      opOr  = 4'd3,
      opShl = 4'd4,
      opShr = 4'd5,
      opNeg = 4'd6,
      opNot = 4'd7
   } aluOp_t;

   // IR layout: opcode in 31..27, then Ra, Rb, Rc and the constant below
   localparam int raLsb      = 23; // Ra in 26..23
   localparam int rbLsb      = 19; // Rb in 22..19
   localparam int rcLsb      = 15; // Rc in 18..15
   localparam int constWidth = 19; // C in 18..0

endpackage

// File: src/busSrcIf.sv
//////////////////////////////////////////////////
// Bus source words and the shared bus
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface busSrcIf;
   import datapathPkg::*;

   word_t pcWord;
   word_t irWord;
   word_t regWord;
   word_t mdrWord;
   word_t zWord;
   word_t busWord;

   modport mux (
      input  pcWord,
      input  irWord,
      input  regWord,
      input  mdrWord,
      input  zWord,
      output busWord
   );

   modport fetch (
      output pcWord,
      output irWord,
      input  busWord
   );

   modport regs (
      output regWord,
      input  irWord,
      input  busWord
   );

   modport mdr (output mdrWord, input busWord);

   modport alu (output zWord, input busWord);

endinterface

// File: src/fetchRegs.sv
//////////////////////////////////////////////////
// PC with increment, IR and MAR
//////////////////////////////////////////////////
`timescale 1ns/1ns

module fetchRegs #(
   parameter datapathPkg::word_t resetPc = '0
) (
   input  logic               clk,
   input  logic               arstN,
   input  logic               incPc,
   input  logic               pcIn,
   input  logic               irIn,
   input  logic               marIn,
   busSrcIf.fetch             bus,
   output datapathPkg::word_t memAddr
);
   import datapathPkg::*;

   localparam word_t pcStep = 32'd4;

   word_t pc;
   word_t ir;
   word_t mar;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= resetPc;
      end else if (pcIn) begin
         pc <= bus.busWord; // Jump target wins over increment
      end else if (incPc) begin
         pc <= pc + pcStep;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ir <= '0;
      end else if (irIn) begin
         ir <= bus.busWord;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         mar <= '0;
      end else if (marIn) begin
         mar <= bus.busWord;
      end
   end

   assign bus.pcWord = pc;
   assign bus.irWord = ir;
   assign memAddr    = mar;

endmodule

// File: src/registerFile.sv
//////////////////////////////////////////////////
// General register file with IR field select
// and the R0 base-address rule
//////////////////////////////////////////////////
`timescale 1ns/1ns

module registerFile #(
   parameter int numRegs = 16
) (
   input  logic  clk,
   input  logic  arstN,
   input  logic  rIn,
   input  logic  rOut,
   input  logic  baOut,
   input  logic  gra,
   input  logic  grb,
   input  logic  grc,
   busSrcIf.regs bus
);
   import datapathPkg::*;

   localparam int idxWidth = $bits(regIdx_t);

   word_t   regs [numRegs];
   regIdx_t sel;
   logic    selValid;
   word_t   selWord;

   // One field at a time is expected from the control steps
   always_comb begin
      if (gra) begin
         sel = bus.irWord[raLsb +: idxWidth];
      end else if (grb) begin
         sel = bus.irWord[rbLsb +: idxWidth];
      end else if (grc) begin
         sel = bus.irWord[rcLsb +: idxWidth];
      end else begin
         sel = '0;
      end
   end

   assign selValid = (int'(sel) < numRegs); // Smaller files ignore high numbers

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (rIn && selValid) begin
         regs[sel] <= bus.busWord; // R0 is writable too
      end
   end

   assign selWord = selValid ? regs[sel] : '0;

   always_comb begin
      if (baOut) begin
         bus.regWord = (sel == '0) ? '0 : selWord; // R0 as base means no base
      end else if (rOut) begin
         bus.regWord = selWord;
      end else begin
         bus.regWord = '0;
      end
   end

endmodule

// File: src/mdrUnit.sv
//////////////////////////////////////////////////
// Memory data register
//////////////////////////////////////////////////
`timescale 1ns/1ns

module mdrUnit (
   input  logic               clk,
   input  logic               arstN,
   input  logic               mdrIn,
   input  logic               read,
   input  datapathPkg::word_t memRdData,
   output datapathPkg::word_t memWrData,
   busSrcIf.mdr               bus
);
   import datapathPkg::*;

   word_t mdr;
   word_t mdrNext;

   assign mdrNext = read ? memRdData : bus.busWord; // Memory side during a read

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         mdr <= '0;
      end else if (mdrIn) begin
         mdr <= mdrNext;
      end
   end

   assign bus.mdrWord = mdr;
   assign memWrData   = mdr;

endmodule

// File: src/aluUnit.sv
//////////////////////////////////////////////////
// Y register, ALU and Z result register
//////////////////////////////////////////////////
`timescale 1ns/1ns

module aluUnit (
   input  logic                clk,
   input  logic                arstN,
   input  logic                yIn,
   input  logic                zIn,
   input  datapathPkg::aluOp_t aluOp,
   busSrcIf.alu                bus
);
   import datapathPkg::*;

   word_t      y;
   word_t      z;
   word_t      result;
   logic [4:0] shamt;

   assign shamt = bus.busWord[4:0];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         y <= '0;
      end else if (yIn) begin
         y <= bus.busWord;
      end
   end

   // Y is the first operand, the bus the second
   always_comb begin
      case (aluOp)
         opAdd:   result = y + bus.busWord;
         opSub:   result = y - bus.busWord;
         opAnd:   result = y & bus.busWord;
         opOr:    result = y | bus.busWord;
         opShl:   result = y << shamt;
         opShr:   result = y >> shamt;  // Logical shift
         opNeg:   result = -bus.busWord; // Unary on the bus alone
         opNot:   result = ~bus.busWord;
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         z <= '0;
      end else if (zIn) begin
         z <= result;
      end
   end

   assign bus.zWord = z;

endmodule

// File: src/busMux.sv
//////////////////////////////////////////////////
// Out-strobe encoder and bus source select
//////////////////////////////////////////////////
`timescale 1ns/1ns

module busMux (
   input  logic pcOut,
   input  logic mdrOut,
   input  logic zOut,
   input  logic rOut,
   input  logic baOut,
   input  logic cOut,
   busSrcIf.mux bus
);
   import datapathPkg::*;

   localparam logic [2:0] selNone  = 3'd0;
   localparam logic [2:0] selPc    = 3'd1;
   localparam logic [2:0] selMdr   = 3'd2;
   localparam logic [2:0] selZ     = 3'd3;
   localparam logic [2:0] selReg   = 3'd4;
   localparam logic [2:0] selConst = 3'd5;

   logic [2:0] srcSel;
   const_t     cField;
   word_t      constWord;

   always_comb begin
      srcSel = selNone;
      if (pcOut)              srcSel = selPc;
      else if (mdrOut)        srcSel = selMdr;
      else if (zOut)          srcSel = selZ;
      else if (rOut || baOut) srcSel = selReg; // Register file handles R0
      else if (cOut)          srcSel = selConst;
   end

   assign cField    = bus.irWord[constWidth-1:0];
   assign constWord = {{($bits(word_t) - constWidth){cField[constWidth-1]}}, cField};

   always_comb begin
      case (srcSel)
         selPc:    bus.busWord = bus.pcWord;
         selMdr:   bus.busWord = bus.mdrWord;
         selZ:     bus.busWord = bus.zWord;
         selReg:   bus.busWord = bus.regWord;
         selConst: bus.busWord = constWord;
         default:  bus.busWord = '0; // Idle bus reads zero
      endcase
   end

endmodule

// File: src/datapath.sv
//////////////////////////////////////////////////
// Datapath top with strobe and memory ports
//////////////////////////////////////////////////
`timescale 1ns/1ns

module datapath #(
   parameter int                 numRegs = 16,
   parameter datapathPkg::word_t resetPc = '0
) (
   input  logic                clk,
   input  logic                arstN,
   input  logic                pcOut,
   input  logic                mdrOut,
   input  logic                zOut,
   input  logic                rOut,
   input  logic                cOut,
   input  logic                baOut,
   input  logic                pcIn,
   input  logic                irIn,
   input  logic                marIn,
   input  logic                mdrIn,
   input  logic                yIn,
   input  logic                zIn,
   input  logic                rIn,
   input  logic                gra,
   input  logic                grb,
   input  logic                grc,
   input  logic                incPc,
   input  logic                read,
   input  logic                write,
   input  datapathPkg::aluOp_t aluOp,
   input  datapathPkg::word_t  memRdData,
   output datapathPkg::word_t  memAddr,
   output datapathPkg::word_t  memWrData,
   output datapathPkg::word_t  busOut,
   output logic                memRead,
   output logic                memWrite
);

   busSrcIf bus ();

   fetchRegs #(.resetPc(resetPc)) i_fetchRegs (
      .clk     (clk),
      .arstN   (arstN),
      .incPc   (incPc),
      .pcIn    (pcIn),
      .irIn    (irIn),
      .marIn   (marIn),
      .bus     (bus.fetch),
      .memAddr (memAddr)
   );

   registerFile #(.numRegs(numRegs)) i_registerFile (
      .clk   (clk),
      .arstN (arstN),
      .rIn   (rIn),
      .rOut  (rOut),
      .baOut (baOut),
      .gra   (gra),
      .grb   (grb),
      .grc   (grc),
      .bus   (bus.regs)
   );

   mdrUnit i_mdrUnit (
      .clk       (clk),
      .arstN     (arstN),
      .mdrIn     (mdrIn),
      .read      (read),
      .memRdData (memRdData),
      .memWrData (memWrData),
      .bus       (bus.mdr)
   );

   aluUnit i_aluUnit (
      .clk   (clk),
      .arstN (arstN),
      .yIn   (yIn),
      .zIn   (zIn),
      .aluOp (aluOp),
      .bus   (bus.alu)
   );

   busMux i_busMux (
      .pcOut  (pcOut),
      .mdrOut (mdrOut),
      .zOut   (zOut),
      .rOut   (rOut),
      .baOut  (baOut),
      .cOut   (cOut),
      .bus    (bus.mux)
   );

   assign memRead  = read; // Memory strobes pass straight through
   assign memWrite = write;
   assign busOut   = bus.busWord;

endmodule

// File: test/datapath_properties.sv
//////////////////////////////////////////////////
// Bound checks on bus and memory strobes
//////////////////////////////////////////////////
`timescale 1ns/1ns

module datapath_properties (
   input logic               clk,
   input logic               arstN,
   input logic               pcOut,
   input logic               mdrOut,
   input logic               zOut,
   input logic               rOut,
   input logic               cOut,
   input logic               baOut,
   input logic               read,
   input logic               write,
   input datapathPkg::word_t memWrData
);

   outStrobesOneHot: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0({pcOut, mdrOut, zOut, rOut, cOut, baOut}))
      else $error("more than one bus source driven in a cycle");

   readWriteExclusive: assert property (@(posedge clk) disable iff (!arstN)
      !(read && write))
      else $error("memory read and write high together");

   // MDR must hold its word through the write edge
   writeDataStable: assert property (@(posedge clk) disable iff (!arstN)
      write |=> $stable(memWrData))
      else $error("memory write data changed across the write");

endmodule

bind datapath datapath_properties i_properties (.*);

// File: test/datapathTb.sv
//////////////////////////////////////////////////
// Datapath testbench with step-driven instructions,
// memory and register model and final report
//////////////////////////////////////////////////
`timescale 1ns/1ns

module datapathTb;
   import datapathPkg::*;

   localparam int    numInstr  = 200;
   localparam int    stepLimit = 30 * numInstr; // Steps allowed per run
   localparam word_t resetPc   = '0;

   logic   clk;
   logic   arstN;
   logic   pcOut, mdrOut, zOut, rOut, cOut, baOut; // Out strobes
   logic   pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn; // In strobes
   logic   gra, grb, grc, incPc, read, write;
   aluOp_t aluOp;
   word_t  memRdData;
   word_t  memAddr;
   word_t  memWrData;
   word_t  busOut;
   logic   memRead;
   logic   memWrite;

   word_t  mem [256];     // Memory, word addressed by bits 9..2
   word_t  regModel [16];
   word_t  pcModel;
   integer seed;
   int     cycles = 0;
   int     instrCount = 0;
   int     numChecks = 0;
   int     wordErrors = 0;
   int     addrErrors = 0;

   datapath #(.numRegs(16), .resetPc(resetPc)) i_datapath (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > stepLimit) begin
         $display("Timeout: no result after %0d clock cycles", stepLimit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      numChecks++;
      if (got !== exp) begin
         wordErrors++;
         $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkAddr(input word_t got, input word_t exp, input string what);
      numChecks++;
      if (got !== exp) begin
         addrErrors++;
         $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Two's complement value of the constant field
   function automatic word_t signExt(input const_t c);
      word_t v;
      v = word_t'(c);
      if (c[constWidth-1]) begin
         v = v - (32'd1 << constWidth);
      end
      return v;
   endfunction

   // Expected ALU result, first operand from Y and second from the bus
   function automatic word_t aluModel(input aluOp_t op, input word_t a, input word_t b);
      case (op)
         opAdd:   return a + b;
         opSub:   return a - b;
         opAnd:   return a & b;
         opOr:    return a | b;
         opShl:   return a << b[4:0];
         opShr:   return a >> b[4:0];
         opNeg:   return 32'd0 - b;
         opNot:   return ~b;
         default: return '0;
      endcase
   endfunction

   task automatic clearStrobes();
      {pcOut, mdrOut, zOut, rOut, cOut, baOut} <= '0;
      {pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn} <= '0;
      {gra, grb, grc, incPc, read, write} <= '0;
   endtask

   task automatic startStep();
      @(posedge clk);
      clearStrobes(); // Caller raises this step's strobes after
   endtask

   task automatic fetch(input word_t instr);
      instrCount++;
      mem[pcModel[9:2]] = instr; // Program word at PC
      startStep(); // T0
      pcOut <= 1'b1;
      marIn <= 1'b1;
      incPc <= 1'b1;
      @(negedge clk);
      checkWord(busOut, pcModel, "PC on bus");
      startStep(); // T1
      read <= 1'b1;
      mdrIn <= 1'b1;
      memRdData <= mem[pcModel[9:2]];
      @(negedge clk);
      checkAddr(memAddr, pcModel, "fetch address");
      checkWord({31'b0, memRead}, 32'd1, "memRead during fetch");
      startStep(); // T2
      mdrOut <= 1'b1;
      irIn <= 1'b1;
      @(negedge clk);
      checkWord(busOut, instr, "fetched word");
      pcModel = pcModel + 32'd4;
   endtask

   task automatic loadConst(input regIdx_t dst);
      word_t instr;
      instr = $random(seed);
      instr[raLsb +: 4] = dst;
      fetch(instr);
      startStep(); // T3
      cOut <= 1'b1;
      gra <= 1'b1;
      rIn <= 1'b1;
      @(negedge clk);
      checkWord(busOut, signExt(instr[constWidth-1:0]), "constant on bus");
      regModel[dst] = signExt(instr[constWidth-1:0]);
   endtask

   task automatic aluInstr();
      word_t   instr;
      word_t   exp;
      aluOp_t  op;
      regIdx_t ra;
      regIdx_t rb;
      regIdx_t rc;
      instr = $random(seed);
      op = aluOp_t'({1'b0, instr[29:27]}); // Low opcode bits pick the operation
      ra = instr[raLsb +: 4];
      rb = instr[rbLsb +: 4];
      rc = instr[rcLsb +: 4];
      loadConst(rb);
      loadConst(rc);
      exp = aluModel(op, regModel[rb], regModel[rc]);
      fetch(instr);
      startStep(); // T3
      grb <= 1'b1;
      rOut <= 1'b1;
      yIn <= 1'b1;
      startStep(); // T4
      grc <= 1'b1;
      rOut <= 1'b1;
      zIn <= 1'b1;
      aluOp <= op;
      startStep(); // T5
      zOut <= 1'b1;
      gra <= 1'b1;
      rIn <= 1'b1;
      @(negedge clk);
      checkWord(busOut, exp, $sformatf("ALU result of %s", op.name()));
      regModel[ra] = exp;
   endtask

   // T3 to T5 shared by load and store, leaving the address in MAR
   task automatic formAddress(input word_t base, input word_t addr);
      startStep(); // T3
      grb <= 1'b1;
      baOut <= 1'b1;
      yIn <= 1'b1;
      @(negedge clk);
      checkWord(busOut, base, "base via baOut");
      startStep(); // T4
      cOut <= 1'b1;
      zIn <= 1'b1;
      aluOp <= opAdd;
      startStep(); // T5
      zOut <= 1'b1;
      marIn <= 1'b1;
      @(negedge clk);
      checkWord(busOut, addr, "effective address");
   endtask

   task automatic memInstr(input logic isStore);
      word_t   instr;
      word_t   base;
      word_t   addr;
      regIdx_t ra;
      regIdx_t rb;
      instr = $random(seed);
      if (($random(seed) & 3) == 0) instr[rbLsb +: 4] = '0; // R0 base often
      ra = instr[raLsb +: 4];
      rb = instr[rbLsb +: 4];
      base = (rb == '0) ? '0 : regModel[rb];
      addr = base + signExt(instr[constWidth-1:0]);
      fetch(instr);
      formAddress(base, addr);
      startStep(); // T6
      if (isStore) begin
         gra <= 1'b1;
         rOut <= 1'b1;
         mdrIn <= 1'b1;
         startStep(); // T7
         write <= 1'b1;
         @(negedge clk);
         checkAddr(memAddr, addr, "store address");
         checkWord(memWrData, regModel[ra], "store data");
         checkWord({31'b0, memWrite}, 32'd1, "memWrite during store");
         mem[addr[9:2]] = regModel[ra]; // Memory takes the word at the step's end
      end else begin
         read <= 1'b1;
         mdrIn <= 1'b1;
         memRdData <= mem[addr[9:2]];
         @(negedge clk);
         checkAddr(memAddr, addr, "load address");
         startStep(); // T7
         mdrOut <= 1'b1;
         gra <= 1'b1;
         rIn <= 1'b1;
         regModel[ra] = mem[addr[9:2]];
         startStep(); // Read back through the register file
         gra <= 1'b1;
         rOut <= 1'b1;
         @(negedge clk);
         checkWord(busOut, regModel[ra], "loaded register");
      end
   endtask

   task automatic jumpInstr();
      word_t   instr;
      regIdx_t ra;
      instr = $random(seed);
      ra = instr[raLsb +: 4];
      fetch(instr);
      startStep(); // T3
      gra <= 1'b1;
      rOut <= 1'b1;
      pcIn <= 1'b1;
      startStep(); // T4
      pcOut <= 1'b1;
      @(negedge clk);
      checkWord(busOut, regModel[ra], "PC after jr");
      pcModel = regModel[ra];
   endtask

   initial begin
      int kind;
      seed = 32'hbf53_b979;
      arstN <= 1'b0;
      clearStrobes();
      aluOp <= opAdd;
      memRdData <= '0;
      pcModel = resetPc;
      for (int i = 0; i < 16; i++) begin
         regModel[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         mem[i] = $random(seed);
      end
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
      checkWord(busOut, '0, "idle bus after reset");
      checkWord({31'b0, memRead}, '0, "memRead after reset");
      checkWord({31'b0, memWrite}, '0, "memWrite after reset");
      while (instrCount < numInstr) begin
         kind = $unsigned($random(seed)) % 5;
         case (kind)
            0:       aluInstr();
            1:       memInstr(1'b0);
            2:       memInstr(1'b1);
            3:       jumpInstr();
            default: loadConst(regIdx_t'($unsigned($random(seed)) % 16));
         endcase
      end
      startStep(); // Bus back to idle
      @(negedge clk);
      $display("Checks: %0d, word errors: %0d, address errors: %0d",
               numChecks, wordErrors, addrErrors);
      if (wordErrors + addrErrors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
src/datapathPkg.sv
src/busSrcIf.sv
src/fetchRegs.sv
src/registerFile.sv
src/mdrUnit.sv
src/aluUnit.sv
src/busMux.sv
src/datapath.sv
test/datapath_properties.sv
test/datapathTb.sv

// File: Makefile
TOP = datapathTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
